/* hdl/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data and address width of the core
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// width of a register index
`define RV_REG_W 5

`endif

/* hdl/rv_pkg.sv */
`include "rv_core_defines.svh"

package rv_pkg;

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LUI, AUIPC, JAL, JALR,
        LB, LH, LW, LBU, LHU, SB, SH, SW,
        ILLEGAL
    } rv_op_e;

    // one instruction word seen in each base format, msb first
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        rv_instr_u           instr;
    } rv_in_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        rv_op_e               op;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  imm;      // already sign extended
        logic                 use_imm;  // second ALU operand is imm instead of rs2
        logic                 writes_rd;
    } rv_decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        rv_op_e               op;
        logic [`RV_REG_W-1:0] rd;
        logic                 wen;
        logic [`RV_XLEN-1:0]  value;    // alu result, link address or effective address
        logic [`RV_XLEN-1:0]  store_data;
        logic                 taken;
        logic [`RV_XLEN-1:0]  target;
    } rv_result_t;

endpackage

/* hdl/rv_decode.sv */
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  rv_pkg::rv_in_t      in_data,
    input  logic                dec_ready,
    output logic                in_ready,
    output logic                dec_valid,
    output rv_pkg::rv_decoded_t dec_data
);
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    rv_pkg::rv_instr_u   instr;
    rv_pkg::rv_decoded_t nxt;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                writes;

    // funct3 picks the ALU operation, alt selects SUB or SRA
    function automatic rv_pkg::rv_op_e alu_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  return rv_pkg::SLL;
            3'b010:  return rv_pkg::SLT;
            3'b011:  return rv_pkg::SLTU;
            3'b100:  return rv_pkg::XOR;
            3'b101:  return alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  return rv_pkg::OR;
            default: return rv_pkg::AND;
        endcase
    endfunction

    assign instr = in_data.instr;

    assign imm_i = {{(`RV_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{(`RV_XLEN-12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{(`RV_XLEN-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                    instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{(`RV_XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                    instr.j.imm_10_1, 1'b0};

    always_comb begin
        nxt = '0;
        writes = 1'b0;
        nxt.pc = in_data.pc;
        nxt.op = rv_pkg::ILLEGAL;
        case (instr.r.opcode)
            OPC_OP: begin
                nxt.op = alu_op(instr.r.funct3, instr.r.funct7[5]);
                nxt.rs1 = instr.r.rs1;
                nxt.rs2 = instr.r.rs2;
                nxt.rd = instr.r.rd;
                writes = 1'b1;
            end
            OPC_OP_IMM: begin
                // only the shifts use bit 30, addi has no subtract form
                nxt.op = alu_op(instr.i.funct3, instr.i.funct3 == 3'b101 && instr.r.funct7[5]);
                nxt.rs1 = instr.i.rs1;
                nxt.rd = instr.i.rd;
                nxt.imm = imm_i;
                nxt.use_imm = 1'b1;
                writes = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                nxt.op = (instr.u.opcode == OPC_LUI) ? rv_pkg::LUI : rv_pkg::AUIPC;
                nxt.rd = instr.u.rd;
                nxt.imm = imm_u;
                nxt.use_imm = 1'b1;
                writes = 1'b1;
            end
            OPC_JAL: begin
                nxt.op = rv_pkg::JAL;
                nxt.rd = instr.j.rd;
                nxt.imm = imm_j;
                writes = 1'b1;
            end
            OPC_JALR: begin
                if (instr.i.funct3 == 3'b000) nxt.op = rv_pkg::JALR;
                nxt.rs1 = instr.i.rs1;
                nxt.rd = instr.i.rd;
                nxt.imm = imm_i;
                nxt.use_imm = 1'b1;
                writes = 1'b1;
            end
            OPC_BRANCH: begin
                case (instr.b.funct3)
                    3'b000:  nxt.op = rv_pkg::BEQ;
                    3'b001:  nxt.op = rv_pkg::BNE;
                    3'b100:  nxt.op = rv_pkg::BLT;
                    3'b101:  nxt.op = rv_pkg::BGE;
                    3'b110:  nxt.op = rv_pkg::BLTU;
                    3'b111:  nxt.op = rv_pkg::BGEU;
                    default: nxt.op = rv_pkg::ILLEGAL;
                endcase
                nxt.rs1 = instr.b.rs1;
                nxt.rs2 = instr.b.rs2;
                nxt.imm = imm_b;
            end
            OPC_LOAD: begin
                case (instr.i.funct3)
                    3'b000:  nxt.op = rv_pkg::LB;
                    3'b001:  nxt.op = rv_pkg::LH;
                    3'b010:  nxt.op = rv_pkg::LW;
                    3'b100:  nxt.op = rv_pkg::LBU;
                    3'b101:  nxt.op = rv_pkg::LHU;
                    default: nxt.op = rv_pkg::ILLEGAL;
                endcase
                nxt.rs1 = instr.i.rs1;
                nxt.rd = instr.i.rd;  // reported but never written, no memory behind it
                nxt.imm = imm_i;
                nxt.use_imm = 1'b1;
            end
            OPC_STORE: begin
                case (instr.s.funct3)
                    3'b000:  nxt.op = rv_pkg::SB;
                    3'b001:  nxt.op = rv_pkg::SH;
                    3'b010:  nxt.op = rv_pkg::SW;
                    default: nxt.op = rv_pkg::ILLEGAL;
                endcase
                nxt.rs1 = instr.s.rs1;
                nxt.rs2 = instr.s.rs2;
                nxt.imm = imm_s;
                nxt.use_imm = 1'b1;
            end
            default: ;
        endcase
        if (nxt.op == rv_pkg::ILLEGAL) begin
            nxt.rs1 = '0;
            nxt.rs2 = '0;
            nxt.rd = '0;
            nxt.imm = '0;
            nxt.use_imm = 1'b0;
        end
        nxt.writes_rd = writes && nxt.op != rv_pkg::ILLEGAL && nxt.rd != '0;
    end

    assign in_ready = !dec_valid || dec_ready;  // slot empty or draining this cycle

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_data <= nxt;
        end
    end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`RV_REG_W-1:0] rs1,
    input  logic [`RV_REG_W-1:0] rs2,
    input  logic                 wen,
    input  logic [`RV_REG_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]  wr_data,
    output logic [`RV_XLEN-1:0]  rs1_data,
    output logic [`RV_XLEN-1:0]  rs2_data
);
    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_execute (
    input  rv_pkg::rv_decoded_t  dec_data,
    input  logic [`RV_XLEN-1:0]  rs1_data,
    input  logic [`RV_XLEN-1:0]  rs2_data,
    output logic [`RV_REG_W-1:0] rs1,
    output logic [`RV_REG_W-1:0] rs2,
    output rv_pkg::rv_result_t   exe_data
);
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] pc_imm;
    logic [`RV_XLEN-1:0] rs1_imm;
    logic [`RV_XLEN-1:0] link;

    assign rs1 = dec_data.rs1;
    assign rs2 = dec_data.rs2;

    assign op_b    = dec_data.use_imm ? dec_data.imm : rs2_data;
    assign shamt   = op_b[4:0];
    assign pc_imm  = dec_data.pc + dec_data.imm;
    assign rs1_imm = rs1_data + dec_data.imm;  // effective address and jalr target
    assign link    = dec_data.pc + `RV_XLEN'd4;

    always_comb begin
        exe_data = '0;
        exe_data.pc = dec_data.pc;
        exe_data.op = dec_data.op;
        exe_data.rd = dec_data.rd;
        exe_data.wen = dec_data.writes_rd;
        case (dec_data.op)
            rv_pkg::ADD:   exe_data.value = rs1_data + op_b;
            rv_pkg::SUB:   exe_data.value = rs1_data - op_b;
            rv_pkg::AND:   exe_data.value = rs1_data & op_b;
            rv_pkg::OR:    exe_data.value = rs1_data | op_b;
            rv_pkg::XOR:   exe_data.value = rs1_data ^ op_b;
            rv_pkg::SLL:   exe_data.value = rs1_data << shamt;
            rv_pkg::SRL:   exe_data.value = rs1_data >> shamt;
            rv_pkg::SRA:   exe_data.value = $signed(rs1_data) >>> shamt;
            rv_pkg::SLT:   exe_data.value = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            rv_pkg::SLTU:  exe_data.value = {{(`RV_XLEN-1){1'b0}}, rs1_data < op_b};
            rv_pkg::BEQ:   exe_data.taken = rs1_data == rs2_data;
            rv_pkg::BNE:   exe_data.taken = rs1_data != rs2_data;
            rv_pkg::BLT:   exe_data.taken = $signed(rs1_data) < $signed(rs2_data);
            rv_pkg::BGE:   exe_data.taken = $signed(rs1_data) >= $signed(rs2_data);
            rv_pkg::BLTU:  exe_data.taken = rs1_data < rs2_data;
            rv_pkg::BGEU:  exe_data.taken = rs1_data >= rs2_data;
            rv_pkg::LUI:   exe_data.value = dec_data.imm;
            rv_pkg::AUIPC: exe_data.value = pc_imm;
            rv_pkg::JAL: begin
                exe_data.taken = 1'b1;
                exe_data.target = pc_imm;
                exe_data.value = link;
            end
            rv_pkg::JALR: begin
                exe_data.taken = 1'b1;
                exe_data.target = {rs1_imm[`RV_XLEN-1:1], 1'b0};
                exe_data.value = link;
            end
            rv_pkg::LB, rv_pkg::LH, rv_pkg::LW, rv_pkg::LBU, rv_pkg::LHU: begin
                exe_data.value = rs1_imm;
            end
            rv_pkg::SB, rv_pkg::SH, rv_pkg::SW: begin
                exe_data.value = rs1_imm;
                exe_data.store_data = rs2_data;
            end
            default: ;
        endcase
        // every branch reports its target whether taken or not
        if (dec_data.op inside {rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT,
                                rv_pkg::BGE, rv_pkg::BLTU, rv_pkg::BGEU}) begin
            exe_data.target = pc_imm;
        end
    end

endmodule

/* hdl/rv_result.sv */
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exe_valid,
    input  rv_pkg::rv_result_t   exe_data,
    input  logic                 out_ready,
    output logic                 exe_ready,
    output logic                 out_valid,
    output rv_pkg::rv_result_t   out_data,
    output logic                 wb_en,
    output logic [`RV_REG_W-1:0] wb_addr,
    output logic [`RV_XLEN-1:0]  wb_data
);
    logic load;

    assign exe_ready = !out_valid || out_ready;  // empty or emptied on this edge
    assign load = exe_valid && exe_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (exe_ready) begin
            out_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= exe_data;
        end
    end

    // The register file takes the write on the same edge that loads the slot, so
    // the next instruction in decode reads the updated value.
    assign wb_en   = load && exe_data.wen;
    assign wb_addr = exe_data.rd;
    assign wb_data = exe_data.value;

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  rv_pkg::rv_in_t     in_data,
    input  logic               out_ready,
    output logic               in_ready,
    output logic               out_valid,
    output rv_pkg::rv_result_t out_data
);
    logic                 dec_valid;
    logic                 dec_ready;
    rv_pkg::rv_decoded_t  dec_data;
    rv_pkg::rv_result_t   exe_data;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic                 wb_en;
    logic [`RV_REG_W-1:0] wb_addr;
    logic [`RV_XLEN-1:0]  wb_data;

    rv_decode u_decode (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_data(in_data),
        .dec_ready(dec_ready), .in_ready(in_ready), .dec_valid(dec_valid),
        .dec_data(dec_data)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .wen(wb_en),
        .wr_addr(wb_addr), .wr_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_execute u_execute (
        .dec_data(dec_data), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1(rs1), .rs2(rs2), .exe_data(exe_data)
    );

    rv_result u_result (
        .clk(clk), .rst(rst), .exe_valid(dec_valid), .exe_data(exe_data),
        .out_ready(out_ready), .exe_ready(dec_ready), .out_valid(out_valid),
        .out_data(out_data), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

endmodule

/* tests/rv_core_asserts.sv */
`timescale 1ns/1ns

module rv_core_asserts (
    input logic               clk,
    input logic               rst,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input rv_pkg::rv_result_t out_data
);
    int fail_count = 0;  // read by the testbench at the end of the run

    assert property (@(posedge clk) !rst |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid is high in the cycle after reset");
        end

    // a stalled result must hold its record until the transfer
    assert property (@(posedge clk) disable iff (!rst)
                     out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_count++;
            $error("out_valid or out_data changed while out_ready was low");
        end

    assert property (@(posedge clk) disable iff (!rst)
                     $fell(in_ready) |-> out_valid && !out_ready)
        else begin
            fail_count++;
            $error("in_ready fell without a stalled output record");
        end

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk(clk), .rst(rst), .in_ready(in_ready), .out_valid(out_valid),
    .out_ready(out_ready), .out_data(out_data)
);

/* tests/rv_core_tb.sv */
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_core_tb;
    localparam int NUM_FAST  = 160;  // back to back, no back-pressure
    localparam int NUM_INSTR = 480;

    logic                clk = 1'b0;
    logic                rst;
    logic                in_valid;
    rv_pkg::rv_in_t      in_data;
    logic                out_ready;
    logic                in_ready;
    logic                out_valid;
    rv_pkg::rv_result_t  out_data;

    logic [31:0]         lfsr;
    logic [`RV_XLEN-1:0] mregs [`RV_NREGS];
    logic [`RV_XLEN-1:0] next_pc;
    logic [31:0]         word;
    rv_pkg::rv_result_t  expected [$];
    rv_pkg::rv_result_t  exp_rec;
    logic                took;
    logic                timed_out;
    int                  value_errs = 0;
    int                  other_errs = 0;
    int                  received = 0;
    int                  issued;
    int                  accepted_cnt;
    int                  stall;
    int                  wait_cycles;

    rv_core UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_data(in_data),
        .out_ready(out_ready), .in_ready(in_ready), .out_valid(out_valid),
        .out_data(out_data)
    );

    always #4 clk = ~clk;

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : (lfsr >> 1);
        end
        return r;
    endfunction

    // first 14 words load x1..x7 with lui/addi, then random classes
    function automatic logic [31:0] make_instr(input int n);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [3:0]  cls;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic        alt;
        rd = 5'(rand_bits(3));
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        f3 = 3'(rand_bits(3));
        cls = 4'(rand_bits(4));
        imm12 = 12'(rand_bits(12));
        imm20 = 20'(rand_bits(20));
        alt = 1'(rand_bits(1));
        if (n < 14) begin
            rd = 5'(n / 2 + 1);
            if (n % 2 == 0) return {imm20, rd, 7'b0110111};
            return {imm12, rd, 3'b000, rd, 7'b0010011};
        end
        case (cls)
            4'd0, 4'd1, 4'd2, 4'd3:
                return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                        7'b0110011};
            4'd4, 4'd5, 4'd6: begin
                if (f3 == 3'd1 || f3 == 3'd5) imm12 = {1'b0, alt && f3 == 3'd5, 5'b0, imm12[4:0]};
                return {imm12, rs1, f3, rd, 7'b0010011};
            end
            4'd7:    return {imm20, rd, 7'b0110111};
            4'd8:    return {imm20, rd, 7'b0010111};
            4'd9:    return {imm20, rd, 7'b1101111};
            4'd10:   return {imm12, rs1, 3'b000, rd, 7'b1100111};
            4'd11, 4'd12: return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b1100011};
            4'd13:   return {imm12, rs1, f3, rd, 7'b0000011};
            4'd14:   return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
            default: return {imm20, rd, alt ? 7'b1110011 : 7'b0001111};  // system and fence
        endcase
    endfunction

    // expected record of one RV32I word, then the model's register update
    function automatic rv_pkg::rv_result_t rv_model(input logic [31:0] pc, input logic [31:0] w);
        rv_pkg::rv_result_t e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ii;
        logic [31:0] opb;
        logic [2:0]  f3;
        logic        alt;
        logic        wr;
        f3 = w[14:12];
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        ii = {{20{w[31]}}, w[31:20]};
        opb = w[5] ? b : ii;
        alt = w[30] && (f3 == 3'd5 || (f3 == 3'd0 && w[5]));
        wr = 1'b0;
        e = '0;
        e.pc = pc;
        e.op = rv_pkg::ILLEGAL;
        case (w[6:0])
            7'b0110011, 7'b0010011: begin
                e.rd = w[11:7];
                wr = 1'b1;
                case (f3)
                    3'd0:    e.op = alt ? rv_pkg::SUB : rv_pkg::ADD;
                    3'd1:    e.op = rv_pkg::SLL;
                    3'd2:    e.op = rv_pkg::SLT;
                    3'd3:    e.op = rv_pkg::SLTU;
                    3'd4:    e.op = rv_pkg::XOR;
                    3'd5:    e.op = alt ? rv_pkg::SRA : rv_pkg::SRL;
                    3'd6:    e.op = rv_pkg::OR;
                    default: e.op = rv_pkg::AND;
                endcase
            end
            7'b0110111, 7'b0010111: begin
                e.op = w[5] ? rv_pkg::LUI : rv_pkg::AUIPC;
                e.rd = w[11:7];
                wr = 1'b1;
                e.value = {w[31:12], 12'b0} + (w[5] ? 32'd0 : pc);
            end
            7'b1101111, 7'b1100111: begin
                if (w[3] || f3 == 3'd0) e.op = w[3] ? rv_pkg::JAL : rv_pkg::JALR;
                e.rd = w[11:7];
                wr = 1'b1;
                e.taken = 1'b1;
                e.value = pc + 32'd4;
                if (w[3]) e.target = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                else e.target = (a + ii) & ~32'd1;
            end
            7'b1100011: begin
                case (f3)
                    3'd0:    e.op = rv_pkg::BEQ;
                    3'd1:    e.op = rv_pkg::BNE;
                    3'd4:    e.op = rv_pkg::BLT;
                    3'd5:    e.op = rv_pkg::BGE;
                    3'd6:    e.op = rv_pkg::BLTU;
                    3'd7:    e.op = rv_pkg::BGEU;
                    default: e.op = rv_pkg::ILLEGAL;
                endcase
                e.target = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b0000011: begin
                case (f3)
                    3'd0:    e.op = rv_pkg::LB;
                    3'd1:    e.op = rv_pkg::LH;
                    3'd2:    e.op = rv_pkg::LW;
                    3'd4:    e.op = rv_pkg::LBU;
                    3'd5:    e.op = rv_pkg::LHU;
                    default: e.op = rv_pkg::ILLEGAL;
                endcase
                e.rd = w[11:7];  // reported, never written
                e.value = a + ii;
            end
            7'b0100011: begin
                case (f3)
                    3'd0:    e.op = rv_pkg::SB;
                    3'd1:    e.op = rv_pkg::SH;
                    3'd2:    e.op = rv_pkg::SW;
                    default: e.op = rv_pkg::ILLEGAL;
                endcase
                e.value = a + {{20{w[31]}}, w[31:25], w[11:7]};
                e.store_data = b;
            end
            default: ;
        endcase
        case (e.op)
            rv_pkg::ADD:  e.value = a + opb;
            rv_pkg::SUB:  e.value = a - opb;
            rv_pkg::SLL:  e.value = a << opb[4:0];
            rv_pkg::SRL:  e.value = a >> opb[4:0];
            rv_pkg::SRA:  e.value = $signed(a) >>> opb[4:0];
            rv_pkg::SLT:  e.value = {31'b0, $signed(a) < $signed(opb)};
            rv_pkg::SLTU: e.value = {31'b0, a < opb};
            rv_pkg::XOR:  e.value = a ^ opb;
            rv_pkg::OR:   e.value = a | opb;
            rv_pkg::AND:  e.value = a & opb;
            rv_pkg::BEQ:  e.taken = a == b;
            rv_pkg::BNE:  e.taken = a != b;
            rv_pkg::BLT:  e.taken = $signed(a) < $signed(b);
            rv_pkg::BGE:  e.taken = $signed(a) >= $signed(b);
            rv_pkg::BLTU: e.taken = a < b;
            rv_pkg::BGEU: e.taken = a >= b;
            default: ;
        endcase
        if (e.op == rv_pkg::ILLEGAL) begin  // an illegal word reports nothing but its pc
            e = '0;
            e.pc = pc;
            e.op = rv_pkg::ILLEGAL;
        end
        e.wen = wr && e.op != rv_pkg::ILLEGAL && e.rd != '0;
        if (e.wen) mregs[e.rd] = e.value;
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (actv === expv)
            else begin
                value_errs++;
                $display("ERR %0t out_data.%s expected %h actual %h", $time, name, expv, actv);
            end
    endtask

    always @(posedge clk) begin
        if (rst && out_valid && out_ready) begin
            assert (expected.size() > 0)
                else begin
                    other_errs++;
                    $display("an output record came out at %0t with none expected", $time);
                end
            if (expected.size() > 0) begin
                exp_rec = expected.pop_front();
                check_field("pc", exp_rec.pc, out_data.pc);
                check_field("op", 32'(exp_rec.op), 32'(out_data.op));
                check_field("rd", 32'(exp_rec.rd), 32'(out_data.rd));
                check_field("wen", 32'(exp_rec.wen), 32'(out_data.wen));
                check_field("value", exp_rec.value, out_data.value);
                check_field("store_data", exp_rec.store_data, out_data.store_data);
                check_field("taken", 32'(exp_rec.taken), 32'(out_data.taken));
                check_field("target", exp_rec.target, out_data.target);
                received++;
            end
        end
    end

    initial begin
        rst = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b1;
        lfsr = 32'hd9de;
        next_pc = 32'h0000_1000;
        issued = 0;
        accepted_cnt = 0;
        stall = 0;
        took = 1'b0;
        timed_out = 1'b0;
        foreach (mregs[i]) mregs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        while (accepted_cnt < NUM_INSTR && !timed_out) begin
            @(negedge clk);
            if (issued >= NUM_FAST) out_ready = (rand_bits(2) != 0);
            if (!in_valid || took) begin
                in_valid = 1'b0;
                if (issued < NUM_INSTR && (issued < NUM_FAST || rand_bits(2) != 0)) begin
                    word = make_instr(issued);
                    in_data = {next_pc, word};
                    expected.push_back(rv_model(next_pc, word));
                    next_pc = next_pc + 32'd4;
                    issued++;
                    in_valid = 1'b1;
                end
            end
            @(posedge clk);
            took = in_valid && in_ready;
            if (took) accepted_cnt++;
            // with out_ready held high every instruction is taken on its first edge
            assert (!(in_valid && !took && issued <= NUM_FAST))
                else begin
                    other_errs++;
                    $display("the core stalled instruction %0d at %0t with out_ready high",
                             issued, $time);
                end
            stall = (in_valid && !took) ? stall + 1 : 0;
            if (stall > 40) begin
                timed_out = 1'b1;
                other_errs++;
                $display("timeout: the core did not accept an instruction for 40 cycles");
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        out_ready = 1'b1;
        wait_cycles = 0;
        while (expected.size() != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (expected.size() != 0) begin
            other_errs++;
            $display("timeout: %0d results never came out of the core", expected.size());
        end
        repeat (4) @(negedge clk);  // catch any duplicated record
        $display("results checked %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 received, value_errs, other_errs, UUT.u_asserts.fail_count);
        if (value_errs == 0 && other_errs == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
tests/rv_core_asserts.sv
tests/rv_core_tb.sv
